//--- src.f
hdl/axis_pkg.sv
hdl/smartnic_pkg.sv
hdl/axis_full_pipe.sv
hdl/host_demux.sv
hdl/axis_pkt_mux.sv
hdl/smartnic_app.sv
tests/tb_smartnic_app.sv

//--- tests/tb_smartnic_app.sv
`timescale 1ns/1ns
`default_nettype none

module tb_smartnic_app
    import axis_pkg::*, smartnic_pkg::*;
;

    localparam int NUM_PORTS     = 2;
    localparam int NUM_SOURCES   = 2 * NUM_PORTS;
    localparam int PKTS_PER_SRC  = 24;
    localparam int HS_TIMEOUT    = 1000;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam logic [31:0] SEED = 32'd7352;

    localparam int DW   = DATA_BYTE_WID * 8;
    localparam int KW   = DATA_BYTE_WID;
    localparam int ID_W = $bits(port_t);
    localparam int IW   = $bits(igr_tdest_t);
    localparam int EW   = $bits(egr_tdest_t);
    localparam int PW   = $bits(pid_t);

    typedef struct packed {
        tdata_t     tdata;
        tkeep_t     tkeep;
        logic       tlast;
        port_t      tid;
        egr_tdest_t tdest;
        pid_t       pid;
    } beat_t;

    localparam int BEAT_W = $bits(beat_t);

    logic                      core_clk;
    logic                      rst;
    logic [NUM_PORTS-1:0]      axis_app_igr_tvalid;
    wire  [NUM_PORTS-1:0]      axis_app_igr_tready;
    logic [NUM_PORTS*DW-1:0]   axis_app_igr_tdata;
    logic [NUM_PORTS*KW-1:0]   axis_app_igr_tkeep;
    logic [NUM_PORTS-1:0]      axis_app_igr_tlast;
    logic [NUM_PORTS*ID_W-1:0] axis_app_igr_tid;
    logic [NUM_PORTS*IW-1:0]   axis_app_igr_tdest;
    logic [NUM_PORTS*PW-1:0]   axis_app_igr_tuser_pid;
    wire  [NUM_PORTS-1:0]      axis_app_egr_tvalid;
    logic [NUM_PORTS-1:0]      axis_app_egr_tready;
    wire  [NUM_PORTS*DW-1:0]   axis_app_egr_tdata;
    wire  [NUM_PORTS*KW-1:0]   axis_app_egr_tkeep;
    wire  [NUM_PORTS-1:0]      axis_app_egr_tlast;
    wire  [NUM_PORTS*ID_W-1:0] axis_app_egr_tid;
    wire  [NUM_PORTS*EW-1:0]   axis_app_egr_tdest;
    wire  [NUM_PORTS*PW-1:0]   axis_app_egr_tuser_pid;
    logic [NUM_PORTS-1:0]      axis_h2c_tvalid;
    wire  [NUM_PORTS-1:0]      axis_h2c_tready;
    logic [NUM_PORTS*DW-1:0]   axis_h2c_tdata;
    logic [NUM_PORTS*KW-1:0]   axis_h2c_tkeep;
    logic [NUM_PORTS-1:0]      axis_h2c_tlast;
    logic [NUM_PORTS*ID_W-1:0] axis_h2c_tid;
    logic [NUM_PORTS*IW-1:0]   axis_h2c_tdest;
    logic [NUM_PORTS*PW-1:0]   axis_h2c_tuser_pid;
    wire  [NUM_PORTS-1:0]      axis_c2h_tvalid;
    logic [NUM_PORTS-1:0]      axis_c2h_tready;
    wire  [NUM_PORTS*DW-1:0]   axis_c2h_tdata;
    wire  [NUM_PORTS*KW-1:0]   axis_c2h_tkeep;
    wire  [NUM_PORTS-1:0]      axis_c2h_tlast;
    wire  [NUM_PORTS*ID_W-1:0] axis_c2h_tid;
    wire  [NUM_PORTS*EW-1:0]   axis_c2h_tdest;
    wire  [NUM_PORTS*PW-1:0]   axis_c2h_tuser_pid;

    // Beats currently driven on each source
    beat_t       igr_cur [NUM_PORTS];
    beat_t       h2c_cur [NUM_PORTS];
    // Expected traffic, per port and per path
    beat_t       c2h_q [NUM_PORTS][$];
    beat_t       app_q [NUM_PORTS][$];
    beat_t       h2c_q [NUM_PORTS][$];
    bit          egr_busy [NUM_PORTS];
    bit          egr_from_h2c [NUM_PORTS];
    logic [31:0] rng_state [NUM_SOURCES+1];
    int          sources_done;

    smartnic_app #(.NUM_PORTS(NUM_PORTS)) dut_i (.*);

    // 100 ns clock
    initial begin
        core_clk = 1'b0;
        forever #50 core_clk = ~core_clk;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopping after first error");
    endtask

    task automatic report_mismatch(input string test_name, input logic [BEAT_W-1:0] expected,
                                   input logic [BEAT_W-1:0] actual);
        stop_run($sformatf("** Error %s: expected %0h, actual %0h", test_name, expected, actual));
    endtask

    // xorshift32, one state per stream
    function automatic logic [31:0] rand32(input int id);
        logic [31:0] x;
        x = rng_state[id];
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state[id] = x;
        return x;
    endfunction

    function automatic bit routes_to_host(input egr_tdest_t dest);
        return dest == HOST0 || dest == HOST1;
    endfunction

    function automatic bit queues_empty();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (c2h_q[p].size() != 0 || app_q[p].size() != 0 || h2c_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic beat_t egr_beat(input int p);
        beat_t b;
        b.tdata = axis_app_egr_tdata[p*DW +: DW];
        b.tkeep = axis_app_egr_tkeep[p*KW +: KW];
        b.tlast = axis_app_egr_tlast[p];
        b.tid   = axis_app_egr_tid[p*ID_W +: ID_W];
        b.tdest = egr_tdest_t'(axis_app_egr_tdest[p*EW +: EW]);
        b.pid   = axis_app_egr_tuser_pid[p*PW +: PW];
        return b;
    endfunction

    function automatic beat_t c2h_beat(input int p);
        beat_t b;
        b.tdata = axis_c2h_tdata[p*DW +: DW];
        b.tkeep = axis_c2h_tkeep[p*KW +: KW];
        b.tlast = axis_c2h_tlast[p];
        b.tid   = axis_c2h_tid[p*ID_W +: ID_W];
        b.tdest = egr_tdest_t'(axis_c2h_tdest[p*EW +: EW]);
        b.pid   = axis_c2h_tuser_pid[p*PW +: PW];
        return b;
    endfunction

    // --------------------
    // Stimulus
    // --------------------
    task automatic set_source(input int p, input bit from_h2c, input logic valid, input beat_t b);
        if (from_h2c) begin
            h2c_cur[p] = b;
            axis_h2c_tvalid[p]             = valid;
            axis_h2c_tdata[p*DW +: DW]     = b.tdata;
            axis_h2c_tkeep[p*KW +: KW]     = b.tkeep;
            axis_h2c_tlast[p]              = b.tlast;
            axis_h2c_tid[p*ID_W +: ID_W]   = b.tid;
            axis_h2c_tdest[p*IW +: IW]     = igr_tdest_t'(b.tdest);
            axis_h2c_tuser_pid[p*PW +: PW] = b.pid;
        end else begin
            igr_cur[p] = b;
            axis_app_igr_tvalid[p]             = valid;
            axis_app_igr_tdata[p*DW +: DW]     = b.tdata;
            axis_app_igr_tkeep[p*KW +: KW]     = b.tkeep;
            axis_app_igr_tlast[p]              = b.tlast;
            axis_app_igr_tid[p*ID_W +: ID_W]   = b.tid;
            axis_app_igr_tdest[p*IW +: IW]     = igr_tdest_t'(b.tdest);
            axis_app_igr_tuser_pid[p*PW +: PW] = b.pid;
        end
    endtask

    task automatic wait_accept(input int p, input bit from_h2c);
        int   cycles;
        logic ready;
        cycles = 0;
        ready  = 1'b0;
        while (!ready) begin
            @(posedge core_clk);
            ready = from_h2c ? axis_h2c_tready[p] : axis_app_igr_tready[p];
            cycles++;
            if (!ready && cycles > HS_TIMEOUT) begin
                stop_run($sformatf("Timeout waiting for %s tready on port %0d",
                                   from_h2c ? "h2c" : "app_igr", p));
            end
        end
        @(negedge core_clk);
    endtask

    task automatic run_source(input int p, input bit from_h2c);
        int          id;
        int          len;
        beat_t       b;
        logic [31:0] r;
        logic [31:0] kr;
        id = 2 * p + int'(from_h2c);
        for (int n = 0; n < PKTS_PER_SRC; n++) begin
            r       = rand32(id);
            len     = 1 + int'(r[1:0]);
            b.tid   = port_t'(p);
            b.tdest = egr_tdest_t'({1'b0, r[3:2]});
            // Source, port and sequence number in the pid
            b.pid   = {from_h2c, p[0], n[13:0]};
            for (int k = 0; k < len; k++) begin
                for (int w = 0; w < DW / 32; w++) begin
                    b.tdata[w*32 +: 32] = rand32(id);
                end
                b.tlast = (k == len - 1);
                if (b.tlast) begin
                    kr      = rand32(id);
                    b.tkeep = {KW{1'b1}} >> kr[5:0];
                end else begin
                    b.tkeep = {KW{1'b1}};
                end
                set_source(p, from_h2c, 1'b1, b);
                wait_accept(p, from_h2c);
            end
            set_source(p, from_h2c, 1'b0, b);
            repeat (int'(r[5:4])) @(negedge core_clk);
        end
        sources_done++;
    endtask

    task automatic drive_stalls();
        logic [31:0] r;
        while (sources_done < NUM_SOURCES) begin
            @(negedge core_clk);
            r = rand32(NUM_SOURCES);
            for (int p = 0; p < NUM_PORTS; p++) begin
                axis_app_egr_tready[p] = |r[2*p +: 2];
                axis_c2h_tready[p]     = |r[2*p+4 +: 2];
            end
        end
    endtask

    // --------------------
    // Scoreboard
    // --------------------
    always @(posedge core_clk) begin : scoreboard
        beat_t b;
        beat_t exp;
        if (!rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (axis_app_igr_tvalid[p] && axis_app_igr_tready[p]) begin
                    if (routes_to_host(igr_cur[p].tdest)) begin
                        c2h_q[p].push_back(igr_cur[p]);
                    end else begin
                        app_q[p].push_back(igr_cur[p]);
                    end
                end
                if (axis_h2c_tvalid[p] && axis_h2c_tready[p]) begin
                    h2c_q[p].push_back(h2c_cur[p]);
                end
                if (axis_c2h_tvalid[p] && axis_c2h_tready[p]) begin
                    b = c2h_beat(p);
                    assert (c2h_q[p].size() != 0)
                        else stop_run($sformatf("Extra beat on c2h of port %0d", p));
                    exp = c2h_q[p].pop_front();
                    assert (b == exp) else report_mismatch("c2h_route", exp, b);
                end
                if (axis_app_egr_tvalid[p] && axis_app_egr_tready[p]) begin
                    b = egr_beat(p);
                    // Source of a packet taken from its first beat
                    if (!egr_busy[p]) begin
                        egr_from_h2c[p] = b.pid[15];
                    end
                    egr_busy[p] = !b.tlast;
                    if (egr_from_h2c[p]) begin
                        assert (h2c_q[p].size() != 0)
                            else stop_run($sformatf("Extra h2c beat on app_egr of port %0d", p));
                        exp = h2c_q[p].pop_front();
                        assert (b == exp) else report_mismatch("h2c_to_egr", exp, b);
                    end else begin
                        assert (app_q[p].size() != 0)
                            else stop_run($sformatf("Extra app beat on app_egr of port %0d", p));
                        exp = app_q[p].pop_front();
                        assert (b == exp) else report_mismatch("app_to_egr", exp, b);
                    end
                end
            end
        end
    end

    a_reset_idle : assert property (@(posedge core_clk)
        rst |=> axis_app_egr_tvalid == '0 && axis_c2h_tvalid == '0)
        else report_mismatch("reset_idle", '0, $sampled({axis_app_egr_tvalid, axis_c2h_tvalid}));

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_chk
        a_egr_port : assert property (@(posedge core_clk) disable iff (rst)
            axis_app_egr_tvalid[p] |-> axis_app_egr_tid[p*ID_W +: ID_W] == port_t'(p))
            else report_mismatch("egr_port", p, $sampled(axis_app_egr_tid[p*ID_W +: ID_W]));
        a_c2h_port : assert property (@(posedge core_clk) disable iff (rst)
            axis_c2h_tvalid[p] |-> axis_c2h_tid[p*ID_W +: ID_W] == port_t'(p))
            else report_mismatch("c2h_port", p, $sampled(axis_c2h_tid[p*ID_W +: ID_W]));
        // Only host destinations may leave on c2h
        a_c2h_dest : assert property (@(posedge core_clk) disable iff (rst)
            axis_c2h_tvalid[p] |-> axis_c2h_tdest[p*EW +: EW] inside {HOST0, HOST1})
            else stop_run($sformatf("** Error c2h_dest: expected 2 or 3, actual %0d",
                                    $sampled(axis_c2h_tdest[p*EW +: EW])));
    end : g_port_chk

    // --------------------
    // Main sequence
    // --------------------
    initial begin : main_seq
        int cycles;
        rst                    = 1'b1;
        axis_app_igr_tvalid    = '0;
        axis_app_igr_tdata     = '0;
        axis_app_igr_tkeep     = '0;
        axis_app_igr_tlast     = '0;
        axis_app_igr_tid       = '0;
        axis_app_igr_tdest     = '0;
        axis_app_igr_tuser_pid = '0;
        axis_h2c_tvalid        = '0;
        axis_h2c_tdata         = '0;
        axis_h2c_tkeep         = '0;
        axis_h2c_tlast         = '0;
        axis_h2c_tid           = '0;
        axis_h2c_tdest         = '0;
        axis_h2c_tuser_pid     = '0;
        axis_app_egr_tready    = '1;
        axis_c2h_tready        = '1;
        sources_done           = 0;
        for (int i = 0; i <= NUM_SOURCES; i++) begin
            rng_state[i] = SEED + 32'(i);
        end
        repeat (4) @(posedge core_clk);
        @(negedge core_clk);
        rst = 1'b0;

        // Nothing sent yet, outputs stay idle
        repeat (3) begin
            @(posedge core_clk);
            assert (axis_app_egr_tvalid == '0 && axis_c2h_tvalid == '0)
                else report_mismatch("reset_idle", '0, {axis_app_egr_tvalid, axis_c2h_tvalid});
        end
        @(negedge core_clk);

        fork
            run_source(0, 1'b0);
            run_source(0, 1'b1);
            run_source(1, 1'b0);
            run_source(1, 1'b1);
            drive_stalls();
        join

        axis_app_egr_tready = '1;
        axis_c2h_tready     = '1;
        cycles = 0;
        while (!queues_empty()) begin
            @(negedge core_clk);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                stop_run("Timeout waiting for queued packets to leave the DUT");
            end
        end

        // Idle window catches late duplicates
        repeat (20) @(negedge core_clk);
        if (queues_empty() && axis_app_egr_tvalid == '0 && axis_c2h_tvalid == '0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_run("Outputs are not idle or packets are still queued at the end of the run");
        end
    end

endmodule : tb_smartnic_app

`default_nettype wire

//--- hdl/smartnic_app.sv
`timescale 1ns/1ns
`default_nettype none

module smartnic_app
    import axis_pkg::*, smartnic_pkg::*;
#(
    parameter int NUM_PORTS = 2
) (
    input  wire                                   core_clk,
    input  wire                                   rst,

    // app_igr stream
    input  wire  [NUM_PORTS-1:0]                  axis_app_igr_tvalid,
    output wire  [NUM_PORTS-1:0]                  axis_app_igr_tready,
    input  wire  [NUM_PORTS*DATA_BYTE_WID*8-1:0]  axis_app_igr_tdata,
    input  wire  [NUM_PORTS*DATA_BYTE_WID-1:0]    axis_app_igr_tkeep,
    input  wire  [NUM_PORTS-1:0]                  axis_app_igr_tlast,
    input  wire  [NUM_PORTS*$bits(port_t)-1:0]    axis_app_igr_tid,
    input  wire  [NUM_PORTS*$bits(igr_tdest_t)-1:0] axis_app_igr_tdest,
    input  wire  [NUM_PORTS*$bits(pid_t)-1:0]     axis_app_igr_tuser_pid,

    // app_egr stream
    output wire  [NUM_PORTS-1:0]                  axis_app_egr_tvalid,
    input  wire  [NUM_PORTS-1:0]                  axis_app_egr_tready,
    output wire  [NUM_PORTS*DATA_BYTE_WID*8-1:0]  axis_app_egr_tdata,
    output wire  [NUM_PORTS*DATA_BYTE_WID-1:0]    axis_app_egr_tkeep,
    output wire  [NUM_PORTS-1:0]                  axis_app_egr_tlast,
    output wire  [NUM_PORTS*$bits(port_t)-1:0]    axis_app_egr_tid,
    output wire  [NUM_PORTS*$bits(egr_tdest_t)-1:0] axis_app_egr_tdest,
    output wire  [NUM_PORTS*$bits(pid_t)-1:0]     axis_app_egr_tuser_pid,

    // h2c stream
    input  wire  [NUM_PORTS-1:0]                  axis_h2c_tvalid,
    output wire  [NUM_PORTS-1:0]                  axis_h2c_tready,
    input  wire  [NUM_PORTS*DATA_BYTE_WID*8-1:0]  axis_h2c_tdata,
    input  wire  [NUM_PORTS*DATA_BYTE_WID-1:0]    axis_h2c_tkeep,
    input  wire  [NUM_PORTS-1:0]                  axis_h2c_tlast,
    input  wire  [NUM_PORTS*$bits(port_t)-1:0]    axis_h2c_tid,
    input  wire  [NUM_PORTS*$bits(igr_tdest_t)-1:0] axis_h2c_tdest,
    input  wire  [NUM_PORTS*$bits(pid_t)-1:0]     axis_h2c_tuser_pid,

    // c2h stream
    output wire  [NUM_PORTS-1:0]                  axis_c2h_tvalid,
    input  wire  [NUM_PORTS-1:0]                  axis_c2h_tready,
    output wire  [NUM_PORTS*DATA_BYTE_WID*8-1:0]  axis_c2h_tdata,
    output wire  [NUM_PORTS*DATA_BYTE_WID-1:0]    axis_c2h_tkeep,
    output wire  [NUM_PORTS-1:0]                  axis_c2h_tlast,
    output wire  [NUM_PORTS*$bits(port_t)-1:0]    axis_c2h_tid,
    output wire  [NUM_PORTS*$bits(egr_tdest_t)-1:0] axis_c2h_tdest,
    output wire  [NUM_PORTS*$bits(pid_t)-1:0]     axis_c2h_tuser_pid
);

    localparam int DATA_W     = DATA_BYTE_WID * 8;
    localparam int ID_W       = $bits(port_t);
    localparam int IGR_DEST_W = $bits(igr_tdest_t);
    localparam int EGR_DEST_W = $bits(egr_tdest_t);
    localparam int PID_W      = $bits(pid_t);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // Stage 0 p4 igr out, 1 demux app branch, 2 app igr out,
        // 3 app egr out, 4 mux out
        logic       s_tvalid [5];
        logic       s_tready [5];
        tdata_t     s_tdata  [5];
        tkeep_t     s_tkeep  [5];
        logic       s_tlast  [5];
        port_t      s_tid    [5];
        egr_tdest_t s_tdest  [5];
        pid_t       s_pid    [5];
        egr_tdest_t app_igr_tdest;
        egr_tdest_t h2c_tdest;

        // Incoming destinations widen to the egress code
        assign app_igr_tdest =
            egr_tdest_t'(EGR_DEST_W'(axis_app_igr_tdest[p*IGR_DEST_W +: IGR_DEST_W]));
        assign h2c_tdest =
            egr_tdest_t'(EGR_DEST_W'(axis_h2c_tdest[p*IGR_DEST_W +: IGR_DEST_W]));

        // --------------------
        // Ingress side
        // --------------------
        axis_full_pipe p4_igr_pipe (
            .core_clk (core_clk), .rst (rst),
            .in_tvalid (axis_app_igr_tvalid[p]), .in_tready (axis_app_igr_tready[p]),
            .in_tdata (axis_app_igr_tdata[p*DATA_W +: DATA_W]),
            .in_tkeep (axis_app_igr_tkeep[p*DATA_BYTE_WID +: DATA_BYTE_WID]),
            .in_tlast (axis_app_igr_tlast[p]), .in_tid (axis_app_igr_tid[p*ID_W +: ID_W]),
            .in_tdest (app_igr_tdest), .in_tuser_pid (axis_app_igr_tuser_pid[p*PID_W +: PID_W]),
            .out_tvalid (s_tvalid[0]), .out_tready (s_tready[0]),
            .out_tdata (s_tdata[0]), .out_tkeep (s_tkeep[0]), .out_tlast (s_tlast[0]),
            .out_tid (s_tid[0]), .out_tdest (s_tdest[0]), .out_tuser_pid (s_pid[0])
        );

        // Host traffic leaves straight to c2h
        host_demux host_demux_i (
            .core_clk (core_clk), .rst (rst),
            .in_tvalid (s_tvalid[0]), .in_tready (s_tready[0]),
            .in_tdata (s_tdata[0]), .in_tkeep (s_tkeep[0]), .in_tlast (s_tlast[0]),
            .in_tid (s_tid[0]), .in_tdest (s_tdest[0]), .in_tuser_pid (s_pid[0]),
            .app_tvalid (s_tvalid[1]), .app_tready (s_tready[1]),
            .app_tdata (s_tdata[1]), .app_tkeep (s_tkeep[1]), .app_tlast (s_tlast[1]),
            .app_tid (s_tid[1]), .app_tdest (s_tdest[1]), .app_tuser_pid (s_pid[1]),
            .host_tvalid (axis_c2h_tvalid[p]), .host_tready (axis_c2h_tready[p]),
            .host_tdata (axis_c2h_tdata[p*DATA_W +: DATA_W]),
            .host_tkeep (axis_c2h_tkeep[p*DATA_BYTE_WID +: DATA_BYTE_WID]),
            .host_tlast (axis_c2h_tlast[p]), .host_tid (axis_c2h_tid[p*ID_W +: ID_W]),
            .host_tdest (axis_c2h_tdest[p*EGR_DEST_W +: EGR_DEST_W]),
            .host_tuser_pid (axis_c2h_tuser_pid[p*PID_W +: PID_W])
        );

        // --------------------
        // Application stages
        // --------------------
        axis_full_pipe app_igr_pipe (
            .core_clk (core_clk), .rst (rst),
            .in_tvalid (s_tvalid[1]), .in_tready (s_tready[1]),
            .in_tdata (s_tdata[1]), .in_tkeep (s_tkeep[1]), .in_tlast (s_tlast[1]),
            .in_tid (s_tid[1]), .in_tdest (s_tdest[1]), .in_tuser_pid (s_pid[1]),
            .out_tvalid (s_tvalid[2]), .out_tready (s_tready[2]),
            .out_tdata (s_tdata[2]), .out_tkeep (s_tkeep[2]), .out_tlast (s_tlast[2]),
            .out_tid (s_tid[2]), .out_tdest (s_tdest[2]), .out_tuser_pid (s_pid[2])
        );

        axis_full_pipe app_egr_pipe (
            .core_clk (core_clk), .rst (rst),
            .in_tvalid (s_tvalid[2]), .in_tready (s_tready[2]),
            .in_tdata (s_tdata[2]), .in_tkeep (s_tkeep[2]), .in_tlast (s_tlast[2]),
            .in_tid (s_tid[2]), .in_tdest (s_tdest[2]), .in_tuser_pid (s_pid[2]),
            .out_tvalid (s_tvalid[3]), .out_tready (s_tready[3]),
            .out_tdata (s_tdata[3]), .out_tkeep (s_tkeep[3]), .out_tlast (s_tlast[3]),
            .out_tid (s_tid[3]), .out_tdest (s_tdest[3]), .out_tuser_pid (s_pid[3])
        );

        // --------------------
        // Egress side
        // --------------------
        axis_pkt_mux axis_pkt_mux_i (
            .core_clk (core_clk), .rst (rst),
            .in0_tvalid (s_tvalid[3]), .in0_tready (s_tready[3]),
            .in0_tdata (s_tdata[3]), .in0_tkeep (s_tkeep[3]), .in0_tlast (s_tlast[3]),
            .in0_tid (s_tid[3]), .in0_tdest (s_tdest[3]), .in0_tuser_pid (s_pid[3]),
            .in1_tvalid (axis_h2c_tvalid[p]), .in1_tready (axis_h2c_tready[p]),
            .in1_tdata (axis_h2c_tdata[p*DATA_W +: DATA_W]),
            .in1_tkeep (axis_h2c_tkeep[p*DATA_BYTE_WID +: DATA_BYTE_WID]),
            .in1_tlast (axis_h2c_tlast[p]), .in1_tid (axis_h2c_tid[p*ID_W +: ID_W]),
            .in1_tdest (h2c_tdest), .in1_tuser_pid (axis_h2c_tuser_pid[p*PID_W +: PID_W]),
            .out_tvalid (s_tvalid[4]), .out_tready (s_tready[4]),
            .out_tdata (s_tdata[4]), .out_tkeep (s_tkeep[4]), .out_tlast (s_tlast[4]),
            .out_tid (s_tid[4]), .out_tdest (s_tdest[4]), .out_tuser_pid (s_pid[4])
        );

        axis_full_pipe p4_egr_pipe (
            .core_clk (core_clk), .rst (rst),
            .in_tvalid (s_tvalid[4]), .in_tready (s_tready[4]),
            .in_tdata (s_tdata[4]), .in_tkeep (s_tkeep[4]), .in_tlast (s_tlast[4]),
            .in_tid (s_tid[4]), .in_tdest (s_tdest[4]), .in_tuser_pid (s_pid[4]),
            .out_tvalid (axis_app_egr_tvalid[p]), .out_tready (axis_app_egr_tready[p]),
            .out_tdata (axis_app_egr_tdata[p*DATA_W +: DATA_W]),
            .out_tkeep (axis_app_egr_tkeep[p*DATA_BYTE_WID +: DATA_BYTE_WID]),
            .out_tlast (axis_app_egr_tlast[p]), .out_tid (axis_app_egr_tid[p*ID_W +: ID_W]),
            .out_tdest (axis_app_egr_tdest[p*EGR_DEST_W +: EGR_DEST_W]),
            .out_tuser_pid (axis_app_egr_tuser_pid[p*PID_W +: PID_W])
        );
    end : g_port

endmodule : smartnic_app

`default_nettype wire

//--- hdl/axis_pkt_mux.sv
`timescale 1ns/1ns
`default_nettype none

module axis_pkt_mux
    import axis_pkg::*, smartnic_pkg::*;
(
    input  wire        core_clk,
    input  wire        rst,

    input  wire        in0_tvalid,
    output logic       in0_tready,
    input  wire        tdata_t in0_tdata,
    input  wire        tkeep_t in0_tkeep,
    input  wire        in0_tlast,
    input  wire        port_t in0_tid,
    input  wire        egr_tdest_t in0_tdest,
    input  wire        pid_t in0_tuser_pid,

    input  wire        in1_tvalid,
    output logic       in1_tready,
    input  wire        tdata_t in1_tdata,
    input  wire        tkeep_t in1_tkeep,
    input  wire        in1_tlast,
    input  wire        port_t in1_tid,
    input  wire        egr_tdest_t in1_tdest,
    input  wire        pid_t in1_tuser_pid,

    output logic       out_tvalid,
    input  wire        out_tready,
    output tdata_t     out_tdata,
    output tkeep_t     out_tkeep,
    output logic       out_tlast,
    output port_t      out_tid,
    output egr_tdest_t out_tdest,
    output pid_t       out_tuser_pid
);

    logic locked;
    logic grant_r;
    logic last_r;
    logic gnt;

    // --------------------
    // Arbitration
    // --------------------
    always_comb begin
        if (locked) begin
            gnt = grant_r;
        end else if (in0_tvalid && in1_tvalid) begin
            // Both waiting, serve the one not served last
            gnt = !last_r;
        end else begin
            gnt = in1_tvalid;
        end
    end

    // Grant locks as soon as a first beat shows, frees after tlast moves
    always_ff @(posedge core_clk) begin
        if (rst) begin
            locked  <= 1'b0;
            grant_r <= 1'b0;
            last_r  <= 1'b1;
        end else if (out_tvalid && out_tready && out_tlast) begin
            locked <= 1'b0;
            last_r <= gnt;
        end else if (out_tvalid) begin
            locked  <= 1'b1;
            grant_r <= gnt;
        end
    end

    // --------------------
    // Data path
    // --------------------
    assign in0_tready = !gnt && out_tready;
    assign in1_tready = gnt && out_tready;

    always_comb begin
        if (gnt) begin
            out_tvalid    = in1_tvalid;
            out_tdata     = in1_tdata;
            out_tkeep     = in1_tkeep;
            out_tlast     = in1_tlast;
            out_tid       = in1_tid;
            out_tdest     = in1_tdest;
            out_tuser_pid = in1_tuser_pid;
        end else begin
            out_tvalid    = in0_tvalid;
            out_tdata     = in0_tdata;
            out_tkeep     = in0_tkeep;
            out_tlast     = in0_tlast;
            out_tid       = in0_tid;
            out_tdest     = in0_tdest;
            out_tuser_pid = in0_tuser_pid;
        end
    end

    // Packets never interleave on the output
    a_grant_held : assert property (@(posedge core_clk) disable iff (rst)
        out_tvalid && !(out_tready && out_tlast) |=> gnt == $past(gnt));

endmodule : axis_pkt_mux

`default_nettype wire

//--- hdl/host_demux.sv
`timescale 1ns/1ns
`default_nettype none

module host_demux
    import axis_pkg::*, smartnic_pkg::*;
(
    input  wire        core_clk,
    input  wire        rst,

    input  wire        in_tvalid,
    output logic       in_tready,
    input  wire        tdata_t in_tdata,
    input  wire        tkeep_t in_tkeep,
    input  wire        in_tlast,
    input  wire        port_t in_tid,
    input  wire        egr_tdest_t in_tdest,
    input  wire        pid_t in_tuser_pid,

    output logic       app_tvalid,
    input  wire        app_tready,
    output tdata_t     app_tdata,
    output tkeep_t     app_tkeep,
    output logic       app_tlast,
    output port_t      app_tid,
    output egr_tdest_t app_tdest,
    output pid_t       app_tuser_pid,

    output logic       host_tvalid,
    input  wire        host_tready,
    output tdata_t     host_tdata,
    output tkeep_t     host_tkeep,
    output logic       host_tlast,
    output port_t      host_tid,
    output egr_tdest_t host_tdest,
    output pid_t       host_tuser_pid
);

    logic in_pkt;
    logic sel_r;
    logic sel;

    // Host branch picked on the first beat, locked until tlast
    assign sel = in_pkt ? sel_r : (in_tdest == HOST0 || in_tdest == HOST1);

    assign in_tready   = sel ? host_tready : app_tready;
    assign app_tvalid  = in_tvalid && !sel;
    assign host_tvalid = in_tvalid && sel;

    // Payload fans out to both branches
    assign app_tdata      = in_tdata;
    assign app_tkeep      = in_tkeep;
    assign app_tlast      = in_tlast;
    assign app_tid        = in_tid;
    assign app_tdest      = in_tdest;
    assign app_tuser_pid  = in_tuser_pid;
    assign host_tdata     = in_tdata;
    assign host_tkeep     = in_tkeep;
    assign host_tlast     = in_tlast;
    assign host_tid       = in_tid;
    assign host_tdest     = in_tdest;
    assign host_tuser_pid = in_tuser_pid;

    always_ff @(posedge core_clk) begin
        if (rst) begin
            in_pkt <= 1'b0;
            sel_r  <= 1'b0;
        end else if (in_tvalid && in_tready) begin
            in_pkt <= !in_tlast;
            sel_r  <= sel;
        end
    end

    a_one_branch : assert property (@(posedge core_clk) disable iff (rst)
        !(app_tvalid && host_tvalid));

    // No branch switch between beats of one packet
    a_branch_held : assert property (@(posedge core_clk) disable iff (rst)
        in_tvalid && in_tready && !in_tlast |=> sel == $past(sel));

endmodule : host_demux

`default_nettype wire

//--- hdl/axis_full_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module axis_full_pipe
    import axis_pkg::*, smartnic_pkg::*;
(
    input  wire        core_clk,
    input  wire        rst,

    input  wire        in_tvalid,
    output logic       in_tready,
    input  wire        tdata_t in_tdata,
    input  wire        tkeep_t in_tkeep,
    input  wire        in_tlast,
    input  wire        port_t in_tid,
    input  wire        egr_tdest_t in_tdest,
    input  wire        pid_t in_tuser_pid,

    output logic       out_tvalid,
    input  wire        out_tready,
    output tdata_t     out_tdata,
    output tkeep_t     out_tkeep,
    output logic       out_tlast,
    output port_t      out_tid,
    output egr_tdest_t out_tdest,
    output pid_t       out_tuser_pid
);

    typedef struct packed {
        tdata_t     tdata;
        tkeep_t     tkeep;
        logic       tlast;
        port_t      tid;
        egr_tdest_t tdest;
        pid_t       pid;
    } beat_t;

    beat_t in_beat;
    beat_t main_beat;
    beat_t skid_beat;
    logic  main_valid;
    logic  skid_valid;

    assign in_beat = {in_tdata, in_tkeep, in_tlast, in_tid, in_tdest, in_tuser_pid};

    // Ready comes straight from a flop, low only with both entries full
    assign in_tready = !skid_valid;

    // --------------------
    // Entry control
    // --------------------
    always_ff @(posedge core_clk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!main_valid || out_tready) begin
            // Main entry drains, refill from skid first
            main_valid <= skid_valid || (in_tvalid && in_tready);
            skid_valid <= 1'b0;
        end else if (in_tvalid && in_tready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge core_clk) begin
        if (!main_valid || out_tready) begin
            main_beat <= skid_valid ? skid_beat : in_beat;
        end
        if (!skid_valid) begin
            skid_beat <= in_beat;
        end
    end

    assign out_tvalid    = main_valid;
    assign out_tdata     = main_beat.tdata;
    assign out_tkeep     = main_beat.tkeep;
    assign out_tlast     = main_beat.tlast;
    assign out_tid       = main_beat.tid;
    assign out_tdest     = main_beat.tdest;
    assign out_tuser_pid = main_beat.pid;

    // Stalled output beat held until taken
    a_out_stable : assert property (@(posedge core_clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(main_beat));

endmodule : axis_full_pipe

`default_nettype wire

//--- hdl/smartnic_pkg.sv
`default_nettype none

package smartnic_pkg;

    // --------------------
    // Port and destination
    // --------------------

    // Source port, carried in tid
    typedef logic [1:0] port_t;

    // Destination as seen on app_igr and h2c
    typedef logic [1:0] igr_tdest_t;

    // Egress destination codes
    typedef enum logic [2:0] {
        CMAC0    = 3'd0,
        CMAC1    = 3'd1,
        HOST0    = 3'd2,
        HOST1    = 3'd3,
        LOOPBACK = 3'd4
    } egr_tdest_t;

    // --------------------
    // Packet metadata
    // --------------------

    // Packet id, the only tuser field still in use
    typedef logic [15:0] pid_t;

endpackage : smartnic_pkg

`default_nettype wire

//--- hdl/axis_pkg.sv
`default_nettype none

package axis_pkg;

    // --------------------
    // Beat geometry
    // --------------------

    // Bytes carried per beat
    localparam int DATA_BYTE_WID = 64;

    // --------------------
    // Beat payload types
    // --------------------

    typedef logic [DATA_BYTE_WID*8-1:0] tdata_t;

    // One enable per data byte
    typedef logic [DATA_BYTE_WID-1:0]   tkeep_t;

endpackage : axis_pkg

`default_nettype wire
